//--- tb.f
+incdir+logic
logic/io_pkg.sv
logic/io_request_queue.sv
logic/io_arbiter.sv
logic/io_register_file.sv
logic/io_subsystem.sv
tb/io_subsystem_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the I/O subsystem testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=io_subsystem_tb

verilator --binary --timing -f tb.f --top-module "$TOP" -o "sim_$TOP"
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./obj_dir/sim_$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Verification failed" "$LOG"; then
	exit 1
fi

exit 0

//--- tb/io_subsystem_tb.sv
//////////////////////////////////////////////////////////////////////
// I/O subsystem testbench
// Directed loads and stores from both cores against a register model
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "io_config.svh"

module io_subsystem_tb
	import io_pkg::*;
	();

	// Cycles allowed before a wake must show up
	localparam int WAKE_TIMEOUT = 40;
	localparam int CONTENTION_TIMEOUT = 200;

	logic clk;
	logic reset;
	logic c0_io_read_en;
	logic c0_io_write_en;
	thread_idx_t c0_io_thread_idx;
	scalar_t c0_io_addr;
	scalar_t c0_io_write_value;
	scalar_t c0_read_value;
	logic c0_rollback_en;
	thread_bitmap_t c0_wake_bitmap;
	logic c1_io_read_en;
	logic c1_io_write_en;
	thread_idx_t c1_io_thread_idx;
	scalar_t c1_io_addr;
	scalar_t c1_io_write_value;
	scalar_t c1_read_value;
	logic c1_rollback_en;
	thread_bitmap_t c1_wake_bitmap;

	// Expected register contents
	scalar_t model[`NUM_IO_REGS];
	int error_count;
	int check_count;
	int test_count;
	int failed_tests;
	int test_errors_start;

	io_subsystem dut0(
		.clk(clk),
		.reset(reset),
		.c0_io_read_en(c0_io_read_en),
		.c0_io_write_en(c0_io_write_en),
		.c0_io_thread_idx(c0_io_thread_idx),
		.c0_io_addr(c0_io_addr),
		.c0_io_write_value(c0_io_write_value),
		.c0_read_value(c0_read_value),
		.c0_rollback_en(c0_rollback_en),
		.c0_wake_bitmap(c0_wake_bitmap),
		.c1_io_read_en(c1_io_read_en),
		.c1_io_write_en(c1_io_write_en),
		.c1_io_thread_idx(c1_io_thread_idx),
		.c1_io_addr(c1_io_addr),
		.c1_io_write_value(c1_io_write_value),
		.c1_read_value(c1_read_value),
		.c1_rollback_en(c1_rollback_en),
		.c1_wake_bitmap(c1_wake_bitmap));

	// 20 ns period
	always #10 clk = ~clk;

	task automatic compare_scalar(input string name, input scalar_t actual,
		input scalar_t expected);
		check_count++;
		if (actual !== expected)
		begin
			$display("FAILED %s: got 0x%h, expected 0x%h", name, actual, expected);
			error_count++;
		end
	endtask

	task automatic compare_bitmap(input string name, input thread_bitmap_t actual,
		input thread_bitmap_t expected);
		check_count++;
		if (actual !== expected)
		begin
			$display("FAILED %s: got 0x%h, expected 0x%h", name, actual, expected);
			error_count++;
		end
	endtask

	task automatic compare_bit(input string name, input logic actual, input logic expected);
		check_count++;
		if (actual !== expected)
		begin
			$display("FAILED %s: got 0x%h, expected 0x%h", name, actual, expected);
			error_count++;
		end
	endtask

	// Timeouts and protocol problems
	task automatic note_failure(input string text);
		$display("%s", text);
		error_count++;
	endtask

	task automatic start_test();
		test_errors_start = error_count;
	endtask

	task automatic finish_test(input string name);
		int errs;

		errs = error_count - test_errors_start;
		test_count++;
		if (errs != 0)
			failed_tests++;
		$display("test %s: %0d errors", name, errs);
	endtask

	// Register index in bits 5:2, random bits above
	function automatic scalar_t make_addr(input reg_idx_t idx);
		scalar_t rnd;

		rnd = $urandom;
		return {rnd[`DATA_WIDTH-1:6], idx, 2'b00};
	endfunction

	function automatic logic core_rollback(input int core);
		return (core == 0) ? c0_rollback_en : c1_rollback_en;
	endfunction

	function automatic scalar_t core_read_value(input int core);
		return (core == 0) ? c0_read_value : c1_read_value;
	endfunction

	function automatic thread_bitmap_t core_wake(input int core);
		return (core == 0) ? c0_wake_bitmap : c1_wake_bitmap;
	endfunction

	task automatic drive_request(input int core, input logic is_store, input thread_idx_t thr,
		input scalar_t addr, input scalar_t wdata);
		if (core == 0)
		begin
			c0_io_read_en <= !is_store;
			c0_io_write_en <= is_store;
			c0_io_thread_idx <= thr;
			c0_io_addr <= addr;
			c0_io_write_value <= wdata;
		end
		else
		begin
			c1_io_read_en <= !is_store;
			c1_io_write_en <= is_store;
			c1_io_thread_idx <= thr;
			c1_io_addr <= addr;
			c1_io_write_value <= wdata;
		end
	endtask

	task automatic drive_idle(input int core);
		if (core == 0)
		begin
			c0_io_read_en <= 1'b0;
			c0_io_write_en <= 1'b0;
		end
		else
		begin
			c1_io_read_en <= 1'b0;
			c1_io_write_en <= 1'b0;
		end
	endtask

	// Reissue after the wake, result shows up one cycle later
	task automatic collect_result(input int core, input logic is_store, input thread_idx_t thr,
		input scalar_t addr, input scalar_t wdata, input scalar_t expected);
		@(posedge clk);
		drive_request(core, is_store, thr, addr, wdata);
		@(posedge clk);
		drive_idle(core);
		@(negedge clk);
		compare_bit($sformatf("c%0d_rollback_en", core), core_rollback(core), 1'b0);
		compare_scalar($sformatf("c%0d_read_value", core), core_read_value(core), expected);
	endtask

	// One full uncontested access, issue then wake then reissue
	task automatic run_access(input int core, input logic is_store, input thread_idx_t thr,
		input scalar_t addr, input scalar_t wdata);
		scalar_t expected;
		thread_bitmap_t one_hot;
		reg_idx_t idx;
		int cycles;

		idx = addr[5:2];
		if (is_store)
			model[idx] = wdata;
		// Stores return the written value on reissue
		expected = is_store ? wdata : model[idx];
		one_hot = '0;
		one_hot[thr] = 1'b1;

		@(posedge clk);
		drive_request(core, is_store, thr, addr, wdata);
		@(posedge clk);
		drive_idle(core);
		@(negedge clk);
		compare_bit($sformatf("c%0d_rollback_en", core), core_rollback(core), 1'b1);

		cycles = 0;
		while (core_wake(core) == '0 && cycles < WAKE_TIMEOUT)
		begin
			if (core_wake(1 - core) != '0)
				note_failure($sformatf("core %0d woke while idle", 1 - core));
			@(negedge clk);
			cycles++;
			// Rollback is a single-cycle pulse
			if (cycles == 1)
				compare_bit($sformatf("c%0d_rollback_en", core), core_rollback(core), 1'b0);
		end

		if (core_wake(core) == '0)
			note_failure($sformatf("timeout waiting for wake of core %0d thread %0d", core, thr));
		else
		begin
			compare_bitmap($sformatf("c%0d_wake_bitmap", core), core_wake(core), one_hot);
			compare_bitmap($sformatf("c%0d_wake_bitmap", 1 - core), core_wake(1 - core), '0);
		end

		collect_result(core, is_store, thr, addr, wdata, expected);
	endtask

	// Responses are serialized, so at most one wake bit per cycle
	task automatic collect_wakes(inout thread_bitmap_t seen0, inout thread_bitmap_t seen1);
		if ($countones({c1_wake_bitmap, c0_wake_bitmap}) > 1)
			note_failure("more than one thread woke in the same cycle");
		seen0 = seen0 | c0_wake_bitmap;
		seen1 = seen1 | c1_wake_bitmap;
	endtask

	task automatic test_reset_state();
		start_test();
		@(negedge clk);
		compare_bit("c0_rollback_en", c0_rollback_en, 1'b0);
		compare_bit("c1_rollback_en", c1_rollback_en, 1'b0);
		compare_bitmap("c0_wake_bitmap", c0_wake_bitmap, '0);
		compare_bitmap("c1_wake_bitmap", c1_wake_bitmap, '0);
		for (int i = 0; i < `NUM_IO_REGS; i++)
			run_access(i % 2, 1'b0, thread_idx_t'(i % 4), make_addr(reg_idx_t'(i)), '0);
		finish_test("reset state");
	endtask

	task automatic test_store_then_load();
		scalar_t addr;
		scalar_t data;

		start_test();
		addr = make_addr(reg_idx_t'($urandom_range(15, 0)));
		data = $urandom;
		run_access(0, 1'b1, thread_idx_t'(1), addr, data);
		run_access(1, 1'b0, thread_idx_t'(3), addr, '0);
		finish_test("store then load");
	endtask

	task automatic test_rollback_timing();
		start_test();
		for (int i = 0; i < 4; i++)
		begin
			run_access(1, 1'b1, thread_idx_t'(i), make_addr(reg_idx_t'(i + 8)), $urandom);
			run_access(0, 1'b0, thread_idx_t'(3 - i), make_addr(reg_idx_t'(i + 8)), '0);
		end
		finish_test("rollback timing");
	endtask

	task automatic test_wake_isolation();
		start_test();
		for (int c = 0; c < `NUM_CORES; c++)
			for (int t = 0; t < `THREADS_PER_CORE; t++)
				run_access(c, 1'b0, thread_idx_t'(t),
					make_addr(reg_idx_t'($urandom_range(15, 0))), '0);
		finish_test("wake isolation");
	endtask

	task automatic test_contention();
		scalar_t addrs[2][4];
		scalar_t values[2][4];
		thread_bitmap_t seen0;
		thread_bitmap_t seen1;
		int cycles;

		start_test();
		seen0 = '0;
		seen1 = '0;
		for (int c = 0; c < 2; c++)
			for (int t = 0; t < 4; t++)
			begin
				addrs[c][t] = make_addr(reg_idx_t'(c * 4 + t));
				values[c][t] = $urandom;
				model[c * 4 + t] = values[c][t];
			end

		// Both cores issue one thread per cycle
		for (int t = 0; t < 4; t++)
		begin
			@(posedge clk);
			drive_request(0, 1'b1, thread_idx_t'(t), addrs[0][t], values[0][t]);
			drive_request(1, 1'b1, thread_idx_t'(t), addrs[1][t], values[1][t]);
			if (t > 0)
			begin
				@(negedge clk);
				compare_bit("c0_rollback_en", c0_rollback_en, 1'b1);
				compare_bit("c1_rollback_en", c1_rollback_en, 1'b1);
				collect_wakes(seen0, seen1);
			end
		end
		@(posedge clk);
		drive_idle(0);
		drive_idle(1);
		@(negedge clk);
		compare_bit("c0_rollback_en", c0_rollback_en, 1'b1);
		compare_bit("c1_rollback_en", c1_rollback_en, 1'b1);
		collect_wakes(seen0, seen1);

		cycles = 0;
		while ((seen0 != '1 || seen1 != '1) && cycles < CONTENTION_TIMEOUT)
		begin
			@(negedge clk);
			collect_wakes(seen0, seen1);
			cycles++;
		end
		if (seen0 != '1 || seen1 != '1)
			note_failure("timeout waiting for all eight threads to wake");
		compare_bitmap("c0 woken threads", seen0, '1);
		compare_bitmap("c1 woken threads", seen1, '1);

		for (int c = 0; c < 2; c++)
			for (int t = 0; t < 4; t++)
				collect_result(c, 1'b1, thread_idx_t'(t), addrs[c][t], values[c][t],
					values[c][t]);

		// Read back crossed over, core 1 reads what core 0 wrote
		for (int c = 0; c < 2; c++)
			for (int t = 0; t < 4; t++)
				run_access(1 - c, 1'b0, thread_idx_t'(3 - t), addrs[c][t], '0);
		finish_test("contention");
	endtask

	task automatic test_address_alias();
		scalar_t addr_a;
		scalar_t addr_b;
		reg_idx_t idx;

		start_test();
		for (int i = 0; i < 4; i++)
		begin
			idx = reg_idx_t'($urandom_range(15, 0));
			addr_a = make_addr(idx);
			addr_b = make_addr(idx);
			// Upper bits must really differ
			if (addr_b[`DATA_WIDTH-1:6] == addr_a[`DATA_WIDTH-1:6])
				addr_b[`DATA_WIDTH-1] = ~addr_b[`DATA_WIDTH-1];
			run_access(i % 2, 1'b1, thread_idx_t'(i), addr_a, $urandom);
			run_access(1 - (i % 2), 1'b0, thread_idx_t'(i), addr_b, '0);
		end
		finish_test("address alias");
	endtask

	initial
	begin
		clk = 1'b0;
		reset = 1'b1;
		c0_io_read_en = 1'b0;
		c0_io_write_en = 1'b0;
		c0_io_thread_idx = '0;
		c0_io_addr = '0;
		c0_io_write_value = '0;
		c1_io_read_en = 1'b0;
		c1_io_write_en = 1'b0;
		c1_io_thread_idx = '0;
		c1_io_addr = '0;
		c1_io_write_value = '0;
		error_count = 0;
		check_count = 0;
		test_count = 0;
		failed_tests = 0;
		test_errors_start = 0;
		for (int i = 0; i < `NUM_IO_REGS; i++)
			model[i] = '0;
		void'($urandom(28));

		repeat (8) @(posedge clk);
		reset <= 1'b0;

		test_reset_state();
		test_store_then_load();
		test_rollback_timing();
		test_wake_isolation();
		test_contention();
		test_address_alias();

		$display("tests %0d, failed tests %0d, checks %0d, errors %0d",
			test_count, failed_tests, check_count, error_count);
		if (error_count == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- logic/io_subsystem.sv
//////////////////////////////////////////////////////////////////////
// I/O subsystem top level
// Two core queues, the arbiter and the register bank
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "io_config.svh"

module io_subsystem
	import io_pkg::*;
	(
	input wire clk,
	input wire reset,

	// Core 0
	input wire c0_io_read_en,
	input wire c0_io_write_en,
	input wire thread_idx_t c0_io_thread_idx,
	input wire scalar_t c0_io_addr,
	input wire scalar_t c0_io_write_value,
	output scalar_t c0_read_value,
	output logic c0_rollback_en,
	output thread_bitmap_t c0_wake_bitmap,

	// Core 1
	input wire c1_io_read_en,
	input wire c1_io_write_en,
	input wire thread_idx_t c1_io_thread_idx,
	input wire scalar_t c1_io_addr,
	input wire scalar_t c1_io_write_value,
	output scalar_t c1_read_value,
	output logic c1_rollback_en,
	output thread_bitmap_t c1_wake_bitmap
	);

	// Queue requests
	logic c0_req_valid;
	logic c0_req_is_store;
	scalar_t c0_req_addr;
	scalar_t c0_req_value;
	thread_idx_t c0_req_thread_idx;
	logic c0_req_ready;
	logic c1_req_valid;
	logic c1_req_is_store;
	scalar_t c1_req_addr;
	scalar_t c1_req_value;
	thread_idx_t c1_req_thread_idx;
	logic c1_req_ready;

	// Shared response
	logic rsp_valid;
	core_id_t rsp_core;
	thread_idx_t rsp_thread_idx;
	scalar_t rsp_read_value;

	// APB
	logic psel;
	logic penable;
	logic pwrite;
	scalar_t paddr;
	scalar_t pwdata;
	scalar_t prdata;
	logic pready;

	io_request_queue #(.CORE_ID(core_id_t'(0))) core0_queue(
		.clk(clk),
		.reset(reset),
		.io_read_en(c0_io_read_en),
		.io_write_en(c0_io_write_en),
		.io_thread_idx(c0_io_thread_idx),
		.io_addr(c0_io_addr),
		.io_write_value(c0_io_write_value),
		.read_value(c0_read_value),
		.rollback_en(c0_rollback_en),
		.wake_bitmap(c0_wake_bitmap),
		.req_valid(c0_req_valid),
		.req_is_store(c0_req_is_store),
		.req_addr(c0_req_addr),
		.req_value(c0_req_value),
		.req_thread_idx(c0_req_thread_idx),
		.req_ready(c0_req_ready),
		.rsp_valid(rsp_valid),
		.rsp_core(rsp_core),
		.rsp_thread_idx(rsp_thread_idx),
		.rsp_read_value(rsp_read_value));

	io_request_queue #(.CORE_ID(core_id_t'(1))) core1_queue(
		.clk(clk),
		.reset(reset),
		.io_read_en(c1_io_read_en),
		.io_write_en(c1_io_write_en),
		.io_thread_idx(c1_io_thread_idx),
		.io_addr(c1_io_addr),
		.io_write_value(c1_io_write_value),
		.read_value(c1_read_value),
		.rollback_en(c1_rollback_en),
		.wake_bitmap(c1_wake_bitmap),
		.req_valid(c1_req_valid),
		.req_is_store(c1_req_is_store),
		.req_addr(c1_req_addr),
		.req_value(c1_req_value),
		.req_thread_idx(c1_req_thread_idx),
		.req_ready(c1_req_ready),
		.rsp_valid(rsp_valid),
		.rsp_core(rsp_core),
		.rsp_thread_idx(rsp_thread_idx),
		.rsp_read_value(rsp_read_value));

	io_arbiter arbiter(
		.clk(clk),
		.reset(reset),
		.c0_req_valid(c0_req_valid),
		.c0_req_is_store(c0_req_is_store),
		.c0_req_addr(c0_req_addr),
		.c0_req_value(c0_req_value),
		.c0_req_thread_idx(c0_req_thread_idx),
		.c0_req_ready(c0_req_ready),
		.c1_req_valid(c1_req_valid),
		.c1_req_is_store(c1_req_is_store),
		.c1_req_addr(c1_req_addr),
		.c1_req_value(c1_req_value),
		.c1_req_thread_idx(c1_req_thread_idx),
		.c1_req_ready(c1_req_ready),
		.rsp_valid(rsp_valid),
		.rsp_core(rsp_core),
		.rsp_thread_idx(rsp_thread_idx),
		.rsp_read_value(rsp_read_value),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready));

	io_register_file register_bank(
		.clk(clk),
		.reset(reset),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready));

endmodule

`default_nettype wire

//--- logic/io_register_file.sv
//////////////////////////////////////////////////////////////////////
// Register bank on APB
// Read/write registers, one wait state on every transfer
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "io_config.svh"

module io_register_file
	import io_pkg::*;
	(
	input wire clk,
	input wire reset,

	// APB slave
	input wire psel,
	input wire penable,
	input wire pwrite,
	input wire scalar_t paddr,
	input wire scalar_t pwdata,
	output scalar_t prdata,
	output logic pready
	);

	scalar_t regs[`NUM_IO_REGS];
	reg_idx_t reg_idx;
	logic wait_done;
	logic access;
	logic complete;

	// Word index from bits 5:2, the rest of the address is ignored
	assign reg_idx = paddr[2 +: $bits(reg_idx_t)];

	assign access = psel && penable;
	// Second access cycle finishes the transfer
	assign complete = access && wait_done;

	assign pready = complete;
	assign prdata = complete ? regs[reg_idx] : '0;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			wait_done <= 1'b0;
			for (int i = 0; i < `NUM_IO_REGS; i++)
				regs[i] <= '0;
		end
		else
		begin
			// First access cycle is the wait state
			if (complete)
				wait_done <= 1'b0;
			else if (access)
				wait_done <= 1'b1;

			if (complete && pwrite)
				regs[reg_idx] <= pwdata;
		end
	end

endmodule

`default_nettype wire

//--- logic/io_arbiter.sv
//////////////////////////////////////////////////////////////////////
// I/O arbiter
// Picks one core request at a time and runs it as an APB transfer
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "io_config.svh"

module io_arbiter
	import io_pkg::*;
	(
	input wire clk,
	input wire reset,

	// Core 0 queue
	input wire c0_req_valid,
	input wire c0_req_is_store,
	input wire scalar_t c0_req_addr,
	input wire scalar_t c0_req_value,
	input wire thread_idx_t c0_req_thread_idx,
	output logic c0_req_ready,

	// Core 1 queue
	input wire c1_req_valid,
	input wire c1_req_is_store,
	input wire scalar_t c1_req_addr,
	input wire scalar_t c1_req_value,
	input wire thread_idx_t c1_req_thread_idx,
	output logic c1_req_ready,

	// Response broadcast to both queues
	output logic rsp_valid,
	output core_id_t rsp_core,
	output thread_idx_t rsp_thread_idx,
	output scalar_t rsp_read_value,

	// APB master
	output logic psel,
	output logic penable,
	output logic pwrite,
	output scalar_t paddr,
	output scalar_t pwdata,
	input wire scalar_t prdata,
	input wire pready
	);

	arb_state_t state;
	core_id_t last_served;
	core_id_t grant_core;
	logic grant_valid;
	logic take;

	// Request held for the whole transfer
	core_id_t cur_core;
	thread_idx_t cur_thread;
	logic cur_is_store;
	scalar_t cur_addr;
	scalar_t cur_value;
	scalar_t cur_rdata;

	// Core grant, the one not served last wins a tie
	always_comb
	begin
		grant_valid = c0_req_valid | c1_req_valid;
		if (c0_req_valid && c1_req_valid)
			grant_core = ~last_served;
		else if (c1_req_valid)
			grant_core = core_id_t'(1);
		else
			grant_core = core_id_t'(0);
	end

	// Ready goes only to the granted core, and only when idle
	assign c0_req_ready = (state == ARB_IDLE) && (grant_core == core_id_t'(0));
	assign c1_req_ready = (state == ARB_IDLE) && (grant_core == core_id_t'(1));
	assign take = (state == ARB_IDLE) && grant_valid;

	// Transfer sequencing
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			state <= ARB_IDLE;
			last_served <= '0;
		end
		else
		begin
			case (state)
				ARB_IDLE:
				begin
					if (take)
					begin
						state <= ARB_SETUP;
						last_served <= grant_core;
					end
				end

				ARB_SETUP:
					state <= ARB_ACCESS;

				// Slave may stretch this phase
				ARB_ACCESS:
				begin
					if (pready)
						state <= ARB_RESPOND;
				end

				ARB_RESPOND:
					state <= ARB_IDLE;

				default:
					state <= ARB_IDLE;
			endcase
		end
	end

	// Latch the granted request and the read data
	always_ff @(posedge clk)
	begin
		if (take)
		begin
			cur_core <= grant_core;
			if (grant_core == core_id_t'(1))
			begin
				cur_thread <= c1_req_thread_idx;
				cur_is_store <= c1_req_is_store;
				cur_addr <= c1_req_addr;
				cur_value <= c1_req_value;
			end
			else
			begin
				cur_thread <= c0_req_thread_idx;
				cur_is_store <= c0_req_is_store;
				cur_addr <= c0_req_addr;
				cur_value <= c0_req_value;
			end
		end

		// Stores answer with zero
		if (state == ARB_ACCESS && pready)
			cur_rdata <= cur_is_store ? '0 : prdata;
	end

	// APB outputs
	assign psel = (state == ARB_SETUP) || (state == ARB_ACCESS);
	assign penable = (state == ARB_ACCESS);
	assign pwrite = cur_is_store;
	assign paddr = cur_addr;
	assign pwdata = cur_value;

	// Tagged response, one cycle
	assign rsp_valid = (state == ARB_RESPOND);
	assign rsp_core = cur_core;
	assign rsp_thread_idx = cur_thread;
	assign rsp_read_value = cur_rdata;

endmodule

`default_nettype wire

//--- logic/io_request_queue.sv
//////////////////////////////////////////////////////////////////////
// I/O request queue, one per core
// Holds one uncached request per thread, rolls back and wakes threads
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "io_config.svh"

module io_request_queue
	import io_pkg::*;
	#(parameter core_id_t CORE_ID = 1'b0)
	(
	input wire clk,
	input wire reset,

	// From the core pipeline
	input wire io_read_en,
	input wire io_write_en,
	input wire thread_idx_t io_thread_idx,
	input wire scalar_t io_addr,
	input wire scalar_t io_write_value,

	// Back to the core pipeline
	output scalar_t read_value,
	output logic rollback_en,
	output thread_bitmap_t wake_bitmap,

	// Request offered to the arbiter
	output logic req_valid,
	output logic req_is_store,
	output scalar_t req_addr,
	output scalar_t req_value,
	output thread_idx_t req_thread_idx,
	input wire req_ready,

	// Response broadcast from the arbiter
	input wire rsp_valid,
	input wire core_id_t rsp_core,
	input wire thread_idx_t rsp_thread_idx,
	input wire scalar_t rsp_read_value
	);

	// Per-thread table, control bits
	thread_bitmap_t entry_valid;
	thread_bitmap_t entry_sent;
	// Per-thread table, payload
	thread_bitmap_t entry_is_store;
	scalar_t entry_addr[`THREADS_PER_CORE];
	scalar_t entry_value[`THREADS_PER_CORE];

	thread_bitmap_t send_request;
	thread_idx_t rr_ptr;
	thread_idx_t send_idx;
	logic send_found;
	logic send_taken;
	logic issue;
	logic first_issue;
	logic rsp_match;

	assign issue = io_read_en | io_write_en;
	// Empty entry means this is the first issue, else it is the reissue
	assign first_issue = issue && !entry_valid[io_thread_idx];

	// Entries waiting to go out to the arbiter
	assign send_request = entry_valid & ~entry_sent;

	// Round-robin pick, starting at the rotating pointer
	always_comb
	begin
		thread_idx_t cand;

		send_found = 1'b0;
		send_idx = rr_ptr;
		for (int i = 0; i < `THREADS_PER_CORE; i++)
		begin
			cand = thread_idx_t'(rr_ptr + i);
			if (!send_found && send_request[cand])
			begin
				send_found = 1'b1;
				send_idx = cand;
			end
		end
	end

	// Offer the picked entry
	assign req_valid = send_found;
	assign req_is_store = entry_is_store[send_idx];
	assign req_addr = entry_addr[send_idx];
	assign req_value = entry_value[send_idx];
	assign req_thread_idx = send_idx;
	assign send_taken = req_valid && req_ready;

	// Only responses tagged with this core count
	assign rsp_match = rsp_valid && (rsp_core == CORE_ID);

	// Wake the thread in the response cycle itself
	always_comb
	begin
		wake_bitmap = '0;
		if (rsp_match)
			wake_bitmap[rsp_thread_idx] = 1'b1;
	end

	// Control state
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			entry_valid <= '0;
			entry_sent <= '0;
			rollback_en <= 1'b0;
			rr_ptr <= '0;
		end
		else
		begin
			// Roll back only on the first issue
			rollback_en <= first_issue;
			if (first_issue)
			begin
				entry_valid[io_thread_idx] <= 1'b1;
				entry_sent[io_thread_idx] <= 1'b0;
			end
			else if (issue)
			begin
				// Reissue collects the result and frees the entry
				entry_valid[io_thread_idx] <= 1'b0;
			end

			// Stop offering once taken, next search starts after it
			if (send_taken)
			begin
				entry_sent[send_idx] <= 1'b1;
				rr_ptr <= send_idx + 1'b1;
			end
		end
	end

	// Payload, no reset
	always_ff @(posedge clk)
	begin
		// Value of the issuing thread, used on reissue
		read_value <= entry_value[io_thread_idx];

		if (first_issue)
		begin
			entry_is_store[io_thread_idx] <= io_write_en;
			entry_addr[io_thread_idx] <= io_addr;
			entry_value[io_thread_idx] <= io_write_value;
		end

		// Loads take the response data; stores keep the written value
		if (rsp_match && !entry_is_store[rsp_thread_idx])
			entry_value[rsp_thread_idx] <= rsp_read_value;
	end

endmodule

`default_nettype wire

//--- logic/io_pkg.sv
//////////////////////////////////////////////////////////////////////
// I/O subsystem types
// Shared vector typedefs and the arbiter state encoding
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "io_config.svh"

package io_pkg;

	// Address or data word
	typedef logic [`DATA_WIDTH-1:0] scalar_t;

	// Thread number within one core
	typedef logic [$clog2(`THREADS_PER_CORE)-1:0] thread_idx_t;

	// Core number
	typedef logic [$clog2(`NUM_CORES)-1:0] core_id_t;

	// One bit per thread
	typedef logic [`THREADS_PER_CORE-1:0] thread_bitmap_t;

	// Index into the register bank
	typedef logic [$clog2(`NUM_IO_REGS)-1:0] reg_idx_t;

	// APB master sequencing
	typedef enum logic [1:0] {
		ARB_IDLE,
		ARB_SETUP,
		ARB_ACCESS,
		ARB_RESPOND
	} arb_state_t;

endpackage

`default_nettype wire

//--- logic/io_config.svh
//////////////////////////////////////////////////////////////////////
// I/O subsystem configuration
// Core, thread and register bank sizes shared by every block
//////////////////////////////////////////////////////////////////////

`ifndef IO_CONFIG_SVH
`define IO_CONFIG_SVH

// Hardware threads per core
`define THREADS_PER_CORE 4

// Cores sharing the register bank
`define NUM_CORES 2

// Registers in the memory-mapped bank
`define NUM_IO_REGS 16

// Width of addresses and data values
`define DATA_WIDTH 32

`endif
